//--- snake_defs.svh
`ifndef SNAKE_DEFS_SVH
`define SNAKE_DEFS_SVH

// Clock cycles between two moves.
`define SNAKE_MOVE_TICKS 16

// Snake length that ends the game with a win.
`define SNAKE_WIN_LENGTH 8

// Start cells, row in the upper two bits.
`define SNAKE_START_HEAD 4'd5
`define SNAKE_START_APPLE 4'd10

// Apple LFSR seed, must be nonzero.
`define SNAKE_LFSR_SEED 4'b1001

`endif

//--- snake_pkg.sv
package snake_pkg;

    // Grid cell, row in [3:2] and column in [1:0].
    typedef logic [3:0] cell_t;

    // Snake length or body memory index.
    typedef logic [3:0] length_t;

    // Direction, 0 right, 1 left, 2 down, 3 up.
    typedef logic [1:0] dir_t;

    // Game sequencer states.
    typedef enum logic [2:0] {
        IDLE,
        WAIT_TICK,
        CHECK,
        SHIFT,
        WRITE_HEAD,
        RENDER,
        OVER,
        WON
    } ctrl_state_t;

endpackage

//--- snake_move_timer.sv
`timescale 1ns/1ps
`include "snake_defs.svh"

module snake_move_timer (
    input  logic clock,
    input  logic reset,
    input  logic timer_clear,
    input  logic timer_enable,
    output logic move_tick
);

    localparam int COUNT_WIDTH = $clog2(`SNAKE_MOVE_TICKS);
    localparam logic [COUNT_WIDTH-1:0] LAST_COUNT = COUNT_WIDTH'(`SNAKE_MOVE_TICKS - 1);

    logic [COUNT_WIDTH-1:0] count;

    // Counts only while waiting for the next move.
    always_ff @(posedge clock) begin
        if (reset || timer_clear) begin
            count <= '0;
        end else if (timer_enable) begin
            if (count == LAST_COUNT) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    assign move_tick = (count == LAST_COUNT);

    // The last count is only ever reached while counting.
    assert property (@(posedge clock) disable iff (reset) move_tick |-> timer_enable);

endmodule

//--- snake_apple_gen.sv
`timescale 1ns/1ps
`include "snake_defs.svh"

module snake_apple_gen (
    input  logic              clock,
    input  logic              reset,
    input  logic              game_init,
    input  logic              apple_load,
    output snake_pkg::cell_t  apple
);

    snake_pkg::cell_t lfsr;

    // Maximal length, x^4 + x^3 + 1, period 15.
    always_ff @(posedge clock) begin
        if (reset) begin
            lfsr <= `SNAKE_LFSR_SEED;
        end else begin
            lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]};
        end
    end

    // New apple taken from the free-running LFSR on each eat.
    always_ff @(posedge clock) begin
        if (reset || game_init) begin
            apple <= `SNAKE_START_APPLE;
        end else if (apple_load) begin
            apple <= lfsr;
        end
    end

    // Zero would lock the LFSR.
    assert property (@(posedge clock) disable iff (reset) lfsr != '0);

endmodule

//--- snake_body_ram.sv
`timescale 1ns/1ps

module snake_body_ram (
    input  logic                clock,
    input  logic                write_enable,
    input  snake_pkg::length_t  write_addr,
    input  snake_pkg::cell_t    write_data,
    input  snake_pkg::length_t  read_addr,
    output snake_pkg::cell_t    read_data
);

    // Index 0 is the head, higher indices toward the tail.
    snake_pkg::cell_t mem [16];

    always_ff @(posedge clock) begin
        if (write_enable) begin
            mem[write_addr] <= write_data;
        end
    end

    // Registered read, one cycle of latency.
    always_ff @(posedge clock) begin
        read_data <= mem[read_addr];
    end

endmodule

//--- snake_datapath.sv
`timescale 1ns/1ps
`include "snake_defs.svh"

module snake_datapath (
    input  logic               clock,
    input  logic               reset,
    input  logic [3:0]         buttons,
    input  logic               game_init,
    input  logic               grow,
    input  logic               shift_load,
    input  logic               shift_step,
    input  logic               write_head,
    input  logic               render_clear,
    input  logic               render_step,
    input  logic               move_commit,
    input  snake_pkg::cell_t   apple,
    output snake_pkg::cell_t   head,
    output snake_pkg::length_t length,
    output logic [15:0]        frame,
    output logic               wall_hit,
    output logic               apple_hit,
    output logic               self_hit,
    output logic               shift_done,
    output logic               render_done,
    output logic               win_reached
);

    logic [3:0]         buttons_q;
    logic [3:0]         button_rise;
    snake_pkg::dir_t    direction;
    snake_pkg::cell_t   next_head;
    snake_pkg::cell_t   step_head;
    snake_pkg::length_t shift_start;
    snake_pkg::length_t shift_addr;
    snake_pkg::length_t render_idx;
    snake_pkg::length_t read_addr;
    snake_pkg::length_t write_addr;
    snake_pkg::cell_t   write_data;
    snake_pkg::cell_t   read_data;
    logic               write_enable;
    logic [15:0]        work_frame;
    logic [15:0]        scan_frame;
    logic               scan_valid;
    logic               scan_self;
    logic               self_flag;

    // Any new press picks the lowest-numbered pressed button.
    assign button_rise = buttons & ~buttons_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            buttons_q <= '0;
        end else begin
            buttons_q <= buttons;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || game_init) begin
            direction <= 2'd0;
        end else if (|button_rise) begin
            if (buttons[0]) begin
                direction <= 2'd0;
            end else if (buttons[1]) begin
                direction <= 2'd1;
            end else if (buttons[2]) begin
                direction <= 2'd2;
            end else begin
                direction <= 2'd3;
            end
        end
    end

    // Neighbour cell and the outward edge test.
    always_comb begin
        case (direction)
            2'd0: begin
                next_head = {head[3:2], head[1:0] + 2'd1};
                wall_hit  = (head[1:0] == 2'd3);
            end
            2'd1: begin
                next_head = {head[3:2], head[1:0] - 2'd1};
                wall_hit  = (head[1:0] == 2'd0);
            end
            2'd2: begin
                next_head = {head[3:2] + 2'd1, head[1:0]};
                wall_hit  = (head[3:2] == 2'd3);
            end
            default: begin
                next_head = {head[3:2] - 2'd1, head[1:0]};
                wall_hit  = (head[3:2] == 2'd0);
            end
        endcase
    end

    assign apple_hit   = (next_head == apple);
    assign win_reached = (length == snake_pkg::length_t'(`SNAKE_WIN_LENGTH));

    // Captured at CHECK so a later press cannot change this move.
    always_ff @(posedge clock) begin
        if (shift_load) begin
            step_head <= next_head;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || game_init) begin
            head   <= `SNAKE_START_HEAD;
            length <= 4'd1;
        end else begin
            if (write_head) begin
                head <= step_head;
            end
            if (grow) begin
                length <= length + 1'b1;
            end
        end
    end

    // Shift starts at the last index of the grown body.
    assign shift_start = grow ? length : length - 1'b1;
    assign shift_done  = (shift_addr == '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            shift_addr <= '0;
        end else if (shift_load) begin
            shift_addr <= shift_start;
        end else if (shift_step) begin
            shift_addr <= shift_addr - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || render_clear) begin
            render_idx <= '0;
        end else if (render_step) begin
            render_idx <= render_idx + 1'b1;
        end
    end

    assign render_done = (render_idx == length);

    // Reads run one entry ahead to hide the memory latency.
    always_comb begin
        if (render_step) begin
            read_addr = render_idx;
        end else if (shift_load) begin
            read_addr = shift_start - 1'b1;
        end else begin
            read_addr = shift_addr - 4'd2;
        end
    end

    assign write_enable = shift_step | write_head;
    assign write_addr   = write_head ? '0 : shift_addr;
    assign write_data   = write_head ? step_head : read_data;

    snake_body_ram i_body_ram (
        .clock        (clock),
        .write_enable (write_enable),
        .write_addr   (write_addr),
        .write_data   (write_data),
        .read_addr    (read_addr),
        .read_data    (read_data)
    );

    // Data for index render_idx - 1 arrives now.
    assign scan_valid = render_step && (render_idx != '0);
    assign scan_frame = work_frame | (scan_valid ? (16'd1 << read_data) : 16'd0);
    assign scan_self  = self_flag
                        | (scan_valid && (render_idx > 4'd1) && (read_data == head));
    assign self_hit   = scan_self;

    always_ff @(posedge clock) begin
        if (render_clear) begin
            work_frame <= 16'd1 << apple;
        end else if (render_step) begin
            work_frame <= scan_frame;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || render_clear) begin
            self_flag <= 1'b0;
        end else if (render_step) begin
            self_flag <= scan_self;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || game_init) begin
            frame <= '0;
        end else if (move_commit) begin
            frame <= scan_frame;
        end
    end

    // The game stops at the win length.
    assert property (@(posedge clock) disable iff (reset)
        length <= snake_pkg::length_t'(`SNAKE_WIN_LENGTH));

endmodule

//--- snake_control.sv
`timescale 1ns/1ps

module snake_control (
    input  logic clock,
    input  logic reset,
    input  logic start,
    input  logic move_tick,
    input  logic wall_hit,
    input  logic apple_hit,
    input  logic self_hit,
    input  logic shift_done,
    input  logic render_done,
    input  logic win_reached,
    output logic timer_clear,
    output logic timer_enable,
    output logic game_init,
    output logic grow,
    output logic apple_load,
    output logic shift_load,
    output logic shift_step,
    output logic write_head,
    output logic render_clear,
    output logic render_step,
    output logic move_commit,
    output logic frame_valid,
    output logic playing,
    output logic game_over,
    output logic game_won
);

    snake_pkg::ctrl_state_t state;
    snake_pkg::ctrl_state_t next_state;

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= snake_pkg::IDLE;
            frame_valid <= 1'b0;
        end else begin
            state       <= next_state;
            frame_valid <= move_commit;
        end
    end

    always_comb begin
        next_state   = state;
        timer_clear  = 1'b0;
        timer_enable = 1'b0;
        game_init    = 1'b0;
        grow         = 1'b0;
        apple_load   = 1'b0;
        shift_load   = 1'b0;
        shift_step   = 1'b0;
        write_head   = 1'b0;
        render_clear = 1'b0;
        render_step  = 1'b0;
        move_commit  = 1'b0;
        case (state)
            snake_pkg::IDLE, snake_pkg::OVER, snake_pkg::WON: begin
                if (start) begin
                    game_init   = 1'b1;
                    timer_clear = 1'b1;
                    next_state  = snake_pkg::WAIT_TICK;
                end
            end
            snake_pkg::WAIT_TICK: begin
                timer_enable = 1'b1;
                if (move_tick) begin
                    next_state = snake_pkg::CHECK;
                end
            end
            snake_pkg::CHECK: begin
                // A wall hit leaves head and body as they are.
                if (wall_hit) begin
                    next_state = snake_pkg::OVER;
                end else begin
                    grow       = apple_hit;
                    apple_load = apple_hit;
                    shift_load = 1'b1;
                    next_state = snake_pkg::SHIFT;
                end
            end
            snake_pkg::SHIFT: begin
                if (shift_done) begin
                    next_state = snake_pkg::WRITE_HEAD;
                end else begin
                    shift_step = 1'b1;
                end
            end
            snake_pkg::WRITE_HEAD: begin
                write_head   = 1'b1;
                render_clear = 1'b1;
                next_state   = snake_pkg::RENDER;
            end
            default: begin
                render_step = 1'b1;
                if (render_done) begin
                    move_commit = 1'b1;
                    if (self_hit) begin
                        next_state = snake_pkg::OVER;
                    end else if (win_reached) begin
                        next_state = snake_pkg::WON;
                    end else begin
                        next_state = snake_pkg::WAIT_TICK;
                    end
                end
            end
        endcase
    end

    assign game_over = (state == snake_pkg::OVER);
    assign game_won  = (state == snake_pkg::WON);
    assign playing   = !(state inside {snake_pkg::IDLE, snake_pkg::OVER, snake_pkg::WON});

    // One frame pulse per move.
    assert property (@(posedge clock) disable iff (reset) frame_valid |=> !frame_valid);

    // A move never starts at the win length.
    assert property (@(posedge clock) disable iff (reset)
        (state == snake_pkg::CHECK) |-> !win_reached);

endmodule

//--- snake_game.sv
`timescale 1ns/1ps

module snake_game (
    input  logic               clock,
    input  logic               reset,
    input  logic               start,
    input  logic [3:0]         buttons,
    output snake_pkg::cell_t   head,
    output snake_pkg::cell_t   apple,
    output snake_pkg::length_t length,
    output logic [15:0]        frame,
    output logic               frame_valid,
    output logic               playing,
    output logic               game_over,
    output logic               game_won
);

    logic timer_clear, timer_enable, move_tick;
    logic game_init, grow, apple_load, move_commit;
    logic shift_load, shift_step, write_head, render_clear, render_step;
    logic wall_hit, apple_hit, self_hit, shift_done, render_done, win_reached;

    snake_control i_control (
        .clock (clock), .reset (reset), .start (start), .move_tick (move_tick),
        .wall_hit (wall_hit), .apple_hit (apple_hit), .self_hit (self_hit),
        .shift_done (shift_done), .render_done (render_done), .win_reached (win_reached),
        .timer_clear (timer_clear), .timer_enable (timer_enable), .game_init (game_init),
        .grow (grow), .apple_load (apple_load), .shift_load (shift_load),
        .shift_step (shift_step), .write_head (write_head), .render_clear (render_clear),
        .render_step (render_step), .move_commit (move_commit), .frame_valid (frame_valid),
        .playing (playing), .game_over (game_over), .game_won (game_won)
    );

    snake_move_timer i_move_timer (
        .clock (clock), .reset (reset), .timer_clear (timer_clear),
        .timer_enable (timer_enable), .move_tick (move_tick)
    );

    snake_apple_gen i_apple_gen (
        .clock (clock), .reset (reset), .game_init (game_init),
        .apple_load (apple_load), .apple (apple)
    );

    snake_datapath i_datapath (
        .clock (clock), .reset (reset), .buttons (buttons), .game_init (game_init),
        .grow (grow), .shift_load (shift_load), .shift_step (shift_step),
        .write_head (write_head), .render_clear (render_clear), .render_step (render_step),
        .move_commit (move_commit), .apple (apple), .head (head), .length (length),
        .frame (frame), .wall_hit (wall_hit), .apple_hit (apple_hit), .self_hit (self_hit),
        .shift_done (shift_done), .render_done (render_done), .win_reached (win_reached)
    );

endmodule

//--- snake_game_tb.sv
`timescale 1ns/1ps
`include "snake_defs.svh"

module snake_game_tb;

    localparam int EVENT_TIMEOUT = 200;

    // Closed tour over all 16 cells, two direction bits per cell.
    localparam logic [31:0] TOUR = 32'h57835B80;

    logic               clock;
    logic               reset;
    logic               start;
    logic [3:0]         buttons;
    snake_pkg::cell_t   head;
    snake_pkg::cell_t   apple;
    snake_pkg::length_t length;
    logic [15:0]        frame;
    logic               frame_valid;
    logic               playing;
    logic               game_over;
    logic               game_won;

    // Body model, index 0 is the head.
    snake_pkg::cell_t   body[$];
    snake_pkg::dir_t    dir;
    snake_pkg::cell_t   model_apple;
    logic [31:0]        rng_state;

    snake_game i_snake_game (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .buttons     (buttons),
        .head        (head),
        .apple       (apple),
        .length      (length),
        .frame       (frame),
        .frame_valid (frame_valid),
        .playing     (playing),
        .game_over   (game_over),
        .game_won    (game_won)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic check_equal(input string name, input int expected, input int actual);
        assert (actual == expected)
            else report_failure($sformatf("FAIL %s expected 0x%0h actual 0x%0h",
                                          name, expected, actual));
    endtask

    // A frame only closes a move that was in play.
    assert property (@(posedge clock) disable iff (reset) frame_valid |-> $past(playing))
        else report_failure("frame_valid pulsed without a move in play");

    // A lost game freezes the snake.
    assert property (@(posedge clock) disable iff (reset)
        game_over && !start |=> $stable(head) && $stable(length))
        else report_failure("head or length changed after game over");

    assert property (@(posedge clock) disable iff (reset)
        game_won |-> length == `SNAKE_WIN_LENGTH)
        else report_failure("game_won is high below the win length");

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Neighbour cell in direction d, -1 past an edge.
    function automatic int next_cell(input snake_pkg::cell_t c, input snake_pkg::dir_t d);
        int row;
        int col;
        row = c[3:2];
        col = c[1:0];
        case (d)
            2'd0: col = col + 1;
            2'd1: col = col - 1;
            2'd2: row = row + 1;
            default: row = row - 1;
        endcase
        if (row < 0 || row > 3 || col < 0 || col > 3) begin
            return -1;
        end
        return row * 4 + col;
    endfunction

    function automatic snake_pkg::dir_t tour_dir(input snake_pkg::cell_t c);
        return TOUR[2 * c +: 2];
    endfunction

    task automatic press_button(input snake_pkg::dir_t d);
        buttons = 4'b0001 << d;
        @(negedge clock);
        buttons = 4'b0000;
    endtask

    task automatic start_game();
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        body.delete();
        body.push_back(`SNAKE_START_HEAD);
        dir = 2'd0;
        model_apple = `SNAKE_START_APPLE;
        check_equal("start_playing", 1, playing);
    endtask

    // Waits for game_over when want_over is set, else for frame_valid.
    task automatic wait_for_event(input string name, input logic want_over);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (cycles > EVENT_TIMEOUT) begin
                report_failure($sformatf("%s timed out waiting for the DUT", name));
            end
        end while (!(want_over ? game_over : frame_valid));
    endtask

    task automatic expect_wall(input string name);
        wait_for_event(name, 1'b1);
        check_equal({name, "_playing"}, 0, playing);
        check_equal({name, "_head"}, body[0], head);
        check_equal({name, "_length"}, body.size(), length);
        repeat (3 * `SNAKE_MOVE_TICKS) begin
            @(negedge clock);
            check_equal({name, "_frame_valid"}, 0, frame_valid);
        end
    endtask

    task automatic apply_move(input snake_pkg::dir_t d, input string name);
        int          target;
        logic        ate;
        logic        bitten;
        logic [15:0] expected;
        press_button(d);
        dir = d;
        target = next_cell(body[0], d);
        if (target < 0) begin
            expect_wall(name);
            return;
        end
        ate = (target == model_apple);
        body.push_front(snake_pkg::cell_t'(target));
        if (!ate) begin
            void'(body.pop_back());
        end
        bitten = 1'b0;
        expected = '0;
        foreach (body[i]) begin
            expected[body[i]] = 1'b1;
            if (i > 0 && body[i] == body[0]) begin
                bitten = 1'b1;
            end
        end
        wait_for_event(name, 1'b0);
        if (ate) begin
            // New apple comes from the LFSR, which skips zero.
            assert (apple != '0) else report_failure({name, " new apple is zero"});
        end else begin
            check_equal({name, "_apple"}, model_apple, apple);
        end
        model_apple = apple;
        expected[model_apple] = 1'b1;
        check_equal({name, "_head"}, body[0], head);
        check_equal({name, "_length"}, body.size(), length);
        check_equal({name, "_frame"}, expected, frame);
        check_equal({name, "_game_over"}, bitten, game_over);
        check_equal({name, "_game_won"}, !bitten && body.size() == `SNAKE_WIN_LENGTH,
                    game_won);
    endtask

    task automatic random_moves(input int count);
        snake_pkg::dir_t d;
        int              target;
        repeat (count) begin
            rng_state = xorshift32(rng_state);
            d = rng_state[1:0];
            target = next_cell(body[0], d);
            // Turn away from walls and the apple so the snake stays one cell long.
            while (target < 0 || target == model_apple) begin
                d = d + 2'd1;
                target = next_cell(body[0], d);
            end
            apply_move(d, "detour");
        end
    endtask

    task automatic follow_tour(input int target_length, input string name);
        int moves;
        moves = 0;
        while (body.size() < target_length) begin
            apply_move(tour_dir(body[0]), name);
            moves++;
            if (moves > 16 * target_length) begin
                report_failure({name, " never reached the apples along the tour"});
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        start = 1'b0;
        buttons = 4'b0000;
        rng_state = 32'h4c52aec8;
        repeat (5) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        check_equal("reset_playing", 0, playing);
        check_equal("reset_game_over", 0, game_over);
        check_equal("reset_game_won", 0, game_won);
        check_equal("reset_frame_valid", 0, frame_valid);
        check_equal("reset_length", 1, length);
        check_equal("reset_head", `SNAKE_START_HEAD, head);
        check_equal("reset_apple", `SNAKE_START_APPLE, apple);
        check_equal("reset_frame", 0, frame);

        // Straight right along row 1 until the edge.
        start_game();
        apply_move(2'd0, "first_move");
        check_equal("first_frame", 16'h0440, frame);
        apply_move(2'd0, "edge_move");
        apply_move(2'd0, "wall_hit");

        start_game();
        random_moves(6);
        follow_tour(`SNAKE_WIN_LENGTH, "tour");
        check_equal("win_flag", 1, game_won);
        check_equal("win_playing", 0, playing);

        // Reversing at length 5 runs the head into the neck.
        start_game();
        follow_tour(5, "grow");
        apply_move(dir ^ 2'd1, "self_hit");
        check_equal("self_hit_over", 1, game_over);
        check_equal("self_hit_playing", 0, playing);

        $display("TEST PASS");
        $finish;
    end

endmodule

//--- snake_game.f
+incdir+.
snake_pkg.sv
snake_move_timer.sv
snake_apple_gen.sv
snake_body_ram.sv
snake_datapath.sv
snake_control.sv
snake_game.sv
snake_game_tb.sv
